/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = exe_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
source/exe_pkg.sv
source/alu_control.sv
source/alu.sv
source/stage_exe.sv
source/branch_resolve.sv
source/exe_top.sv
test/exe_tb.sv

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0]      a_i,
    input  logic [31:0]      b_i,
    input  exe_pkg::alu_op_e op_i,
    output logic [31:0]      result_o,
    output logic             zero_o
);

    // Shared adder path, add and sub
    logic [31:0] sum;
    logic [31:0] diff;
    // Signed compare for slt
    logic        less;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    assign less = $signed(a_i) < $signed(b_i);

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (op_i)
            exe_pkg::alu_and:
            begin
                result_o = a_i & b_i;
            end
            exe_pkg::alu_or:
            begin
                result_o = a_i | b_i;
            end
            exe_pkg::alu_add:
            begin
                result_o = sum;
            end
            exe_pkg::alu_sub:
            begin
                result_o = diff;
            end
            exe_pkg::alu_slt:
            begin
                // Only bit 0 carries the compare
                result_o = {31'd0, less};
            end
            exe_pkg::alu_nor:
            begin
                result_o = ~(a_i | b_i);
            end
            default:
            begin
                result_o = 32'd0;
            end
        endcase
    end

    // Zero flag, used by beq and bne
    assign zero_o = (result_o == 32'd0);

endmodule

/* source/alu_control.sv */
`timescale 1ns/1ps

module alu_control (
    input  logic             clock_i,
    input  logic             reset_i,
    input  exe_pkg::oper_e   oper_i,
    input  logic [5:0]       funct_i,
    output exe_pkg::alu_op_e alu_op_o
);

    // Decoded funct field, only meaningful for R-type
    exe_pkg::alu_op_e funct_op;

    // R-type funct decode
    always_comb
    begin
        case (funct_i)
            exe_pkg::funct_add: funct_op = exe_pkg::alu_add;
            exe_pkg::funct_sub: funct_op = exe_pkg::alu_sub;
            exe_pkg::funct_and: funct_op = exe_pkg::alu_and;
            exe_pkg::funct_or:  funct_op = exe_pkg::alu_or;
            exe_pkg::funct_nor: funct_op = exe_pkg::alu_nor;
            exe_pkg::funct_slt: funct_op = exe_pkg::alu_slt;
            // Unknown funct behaves as add
            default:            funct_op = exe_pkg::alu_add;
        endcase
    end

    // Class to operation
    always_comb
    begin
        case (oper_i)
            // Loads, stores, addi
            exe_pkg::oper_add:   alu_op_o = exe_pkg::alu_add;
            // Branch compare by subtraction
            exe_pkg::oper_sub:   alu_op_o = exe_pkg::alu_sub;
            exe_pkg::oper_funct: alu_op_o = funct_op;
            exe_pkg::oper_and:   alu_op_o = exe_pkg::alu_and;
            exe_pkg::oper_or:    alu_op_o = exe_pkg::alu_or;
            exe_pkg::oper_slt:   alu_op_o = exe_pkg::alu_slt;
            // Unused class codes
            default:             alu_op_o = exe_pkg::alu_add;
        endcase
    end

    // Decode only hands over the defined operation classes
    a_legal_oper: assert property (
        @(posedge clock_i) disable iff (reset_i)
        oper_i inside {exe_pkg::oper_add, exe_pkg::oper_sub, exe_pkg::oper_funct,
                       exe_pkg::oper_and, exe_pkg::oper_or, exe_pkg::oper_slt}
    ) else $error("alu_control received unused operation class %b", oper_i);

endmodule

/* source/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve (
    input  logic                   clock_i,
    input  logic                   reset_i,
    input  exe_pkg::fetch_bundle_t fetch_i,
    output logic                   pc_load_o,
    output logic [31:0]            pc_target_o
);

    // Taken conditions
    logic eq_taken;
    logic ne_taken;

    // beq taken on zero difference
    assign eq_taken = fetch_i.branch_eq & fetch_i.zero;

    // bne taken on nonzero difference
    assign ne_taken = fetch_i.branch_ne & ~fetch_i.zero;

    ////////////////////////////////////////////////////////////////////////////
    // PC load towards fetch
    ////////////////////////////////////////////////////////////////////////////

    // Jump loads unconditionally
    assign pc_load_o = fetch_i.is_jump | eq_taken | ne_taken;

    // Same target for jumps and branches
    assign pc_target_o = fetch_i.jump_address;

    // Registered flags from the stage never carry both branch kinds
    a_one_branch_kind: assert property (
        @(posedge clock_i) disable iff (reset_i)
        !(fetch_i.branch_eq && fetch_i.branch_ne)
    ) else $error("branch_eq and branch_ne both set");

endmodule

/* source/exe_pkg.sv */
package exe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Operation classes and ALU operations
    ////////////////////////////////////////////////////////////////////////////

    // Operation class handed over by decode
    typedef enum logic [3:0] {
        oper_add   = 4'd0,
        oper_sub   = 4'd1,
        oper_funct = 4'd2,
        oper_and   = 4'd3,
        oper_or    = 4'd4,
        oper_slt   = 4'd5
    } oper_e;

    // ALU operation, classic MIPS ALU-control encoding
    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_or  = 4'b0001,
        alu_add = 4'b0010,
        alu_sub = 4'b0110,
        alu_slt = 4'b0111,
        alu_nor = 4'b1100
    } alu_op_e;

    // R-type funct codes
    localparam logic [5:0] funct_add = 6'h20;
    localparam logic [5:0] funct_sub = 6'h22;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or  = 6'h25;
    localparam logic [5:0] funct_nor = 6'h27;
    localparam logic [5:0] funct_slt = 6'h2a;

    ////////////////////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////////////////////

    // Data path inputs from decode
    typedef struct packed {
        logic [31:0] data_a;
        logic [31:0] data_b;
        logic [31:0] data_imm;
        logic [31:0] npc;
        logic [4:0]  regaddr_rt;
        logic [4:0]  regaddr_rd;
    } exe_operand_t;

    // Decode controls
    typedef struct packed {
        oper_e       oper;
        logic        use_imm;
        // Set picks rd as destination
        logic        reg_dst;
        logic        is_jump;
        logic        branch_eq;
        logic        branch_ne;
        logic [1:0]  wb;
        logic        mem;
    } exe_control_t;

    // Towards the memory stage
    typedef struct packed {
        logic [1:0]  wb;
        logic        mem;
        logic [4:0]  regaddr;
        logic [31:0] store_data;
        logic [31:0] result;
    } mem_bundle_t;

    // Registered flags towards fetch
    typedef struct packed {
        logic        is_jump;
        logic        branch_eq;
        logic        branch_ne;
        logic        zero;
        logic [31:0] jump_address;
    } fetch_bundle_t;

endpackage

/* source/exe_top.sv */
`timescale 1ns/1ps

module exe_top (
    input  logic                  clock,
    input  logic                  reset,
    input  exe_pkg::exe_operand_t operand_i,
    input  exe_pkg::exe_control_t control_i,
    output exe_pkg::mem_bundle_t  mem_o,
    output logic                  pc_load_o,
    output logic [31:0]           pc_target_o
);

    // Registered flags between stage and resolver
    exe_pkg::fetch_bundle_t fetch_w;

    ////////////////////////////////////////////////////////////////////////////
    // Execute stage
    ////////////////////////////////////////////////////////////////////////////

    stage_exe u_stage (
        .clock     (clock),
        .reset     (reset),
        .operand_i (operand_i),
        .control_i (control_i),
        .mem_o     (mem_o),
        .fetch_o   (fetch_w)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Fetch-side resolver
    ////////////////////////////////////////////////////////////////////////////

    // Same cycle as the registered flags
    branch_resolve u_resolve (
        .clock_i     (clock),
        .reset_i     (reset),
        .fetch_i     (fetch_w),
        .pc_load_o   (pc_load_o),
        .pc_target_o (pc_target_o)
    );

endmodule

/* source/stage_exe.sv */
`timescale 1ns/1ps

module stage_exe (
    input  logic                   clock,
    input  logic                   reset,
    input  exe_pkg::exe_operand_t  operand_i,
    input  exe_pkg::exe_control_t  control_i,
    output exe_pkg::mem_bundle_t   mem_o,
    output exe_pkg::fetch_bundle_t fetch_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Combinational execute path
    ////////////////////////////////////////////////////////////////////////////

    // Second ALU operand
    logic [31:0]            operand_b;
    // ALU operation and outputs
    exe_pkg::alu_op_e       alu_op;
    logic [31:0]            alu_result;
    logic                   alu_zero;
    // Branch or jump target
    logic [31:0]            target;
    // Destination register
    logic [4:0]             dest_reg;
    // Next register contents
    exe_pkg::mem_bundle_t   mem_next;
    exe_pkg::fetch_bundle_t fetch_next;

    // Immediate or register for port b
    assign operand_b = control_i.use_imm ? operand_i.data_imm : operand_i.data_b;

    // Target is next PC plus raw immediate, no shift
    assign target = operand_i.npc + operand_i.data_imm;

    // rd for R-type, rt otherwise
    assign dest_reg = control_i.reg_dst ? operand_i.regaddr_rd : operand_i.regaddr_rt;

    // Funct sits in the low bits of the immediate
    alu_control u_alu_control (
        .clock_i  (clock),
        .reset_i  (reset),
        .oper_i   (control_i.oper),
        .funct_i  (operand_i.data_imm[5:0]),
        .alu_op_o (alu_op)
    );

    alu u_alu (
        .a_i      (operand_i.data_a),
        .b_i      (operand_b),
        .op_i     (alu_op),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    // Bundle for the memory stage
    always_comb
    begin
        mem_next.wb         = control_i.wb;
        mem_next.mem        = control_i.mem;
        mem_next.regaddr    = dest_reg;
        // Store data bypasses the operand mux
        mem_next.store_data = operand_i.data_b;
        mem_next.result     = alu_result;
    end

    // Bundle for fetch
    always_comb
    begin
        fetch_next.is_jump      = control_i.is_jump;
        fetch_next.branch_eq    = control_i.branch_eq;
        fetch_next.branch_ne    = control_i.branch_ne;
        fetch_next.zero         = alu_zero;
        fetch_next.jump_address = target;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute/memory register
    ////////////////////////////////////////////////////////////////////////////

    // One instruction per cycle, no stall
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            mem_o   <= '0;
            fetch_o <= '0;
        end
        else
        begin
            mem_o   <= mem_next;
            fetch_o <= fetch_next;
        end
    end

    // Decode never marks an instruction as both jump and branch
    a_jump_xor_branch: assert property (
        @(posedge clock) disable iff (reset)
        !(control_i.is_jump && (control_i.branch_eq || control_i.branch_ne))
    ) else $error("jump and branch flags set together");

endmodule

/* test/exe_input.txt */
// Stimulus oper use_imm reg_dst is_jump branch_eq branch_ne wb mem data_a data_b data_imm npc rt rd
// Expected wb mem regaddr store_data result pc_load pc_target
// R-type with funct in the low immediate bits
2 0 1 0 0 0 1 0  00000005 00000003 00000020 00001004 02 03  1 0 03 00000003 00000008 0 00001024
2 0 1 0 0 0 1 0  00000005 00000007 00000022 00001008 04 05  1 0 05 00000007 fffffffe 0 0000102a
2 0 1 0 0 0 1 0  f0f0f0f0 ff00ff00 00000024 0000100c 06 07  1 0 07 ff00ff00 f000f000 0 00001030
2 0 1 0 0 0 1 0  f0f0f0f0 0f0f0000 00000025 00001010 08 09  1 0 09 0f0f0000 fffff0f0 0 00001035
2 0 1 0 0 0 1 0  00ff00ff 0f0f0f0f 00000027 00001014 0a 0b  1 0 0b 0f0f0f0f f000f000 0 0000103b
2 0 1 0 0 0 1 0  ffffffff 00000001 0000002a 00001018 0c 0d  1 0 0d 00000001 00000001 0 00001042
2 0 1 0 0 0 1 0  00000001 ffffffff 0000002a 0000101c 0e 0f  1 0 0f ffffffff 00000000 0 00001046
2 0 1 0 0 0 1 0  7fffffff 00000001 0000003f 00001020 10 11  1 0 11 00000001 80000000 0 0000105f
2 0 1 0 0 0 1 0  00000100 00000200 ffff0020 00001024 12 13  1 0 13 00000200 00000300 0 ffff1044
2 0 1 0 0 0 1 0  12345678 12345678 00000022 00001028 14 15  1 0 15 12345678 00000000 0 0000104a
// Immediate forms, loads and stores
0 1 0 0 0 0 1 0  00000064 deadbeef fffffff6 00002000 08 1f  1 0 08 deadbeef 0000005a 0 00001ff6
3 1 0 0 0 0 1 0  12345678 00000abc 0000ff00 00002004 09 1e  1 0 09 00000abc 00005600 0 00011f04
4 1 0 0 0 0 1 0  12340000 00000000 00005678 00002008 0a 1d  1 0 0a 00000000 12345678 0 00007680
5 1 0 0 0 0 1 0  fffffff0 00000005 fffffff8 0000200c 0b 1c  1 0 0b 00000005 00000001 0 00002004
5 1 0 0 0 0 1 0  00000010 00000000 00000010 00002010 0c 1b  1 0 0c 00000000 00000000 0 00002020
0 1 0 0 0 0 3 0  10000000 00000000 00000004 00002014 0d 1a  3 0 0d 00000000 10000004 0 00002018
0 1 0 0 0 0 0 1  10000000 cafef00d fffffffc 00002018 0e 19  0 1 0e cafef00d 0ffffffc 0 00002014
0 1 0 0 0 0 3 0  00000100 55555555 00000010 0000201c 0f 18  3 0 0f 55555555 00000110 0 0000202c
// Branches compare by subtraction
1 0 0 0 1 0 0 0  00000007 00000007 00000010 00003000 01 02  0 0 01 00000007 00000000 1 00003010
1 0 0 0 1 0 0 0  00000007 00000008 00000010 00003004 03 04  0 0 03 00000008 ffffffff 0 00003014
1 0 0 0 0 1 0 0  abcdef01 abcdef01 fffffff0 00003008 05 06  0 0 05 abcdef01 00000000 0 00002ff8
1 0 0 0 0 1 0 0  00000001 00000000 00000020 0000300c 07 08  0 0 07 00000000 00000001 1 0000302c
1 0 0 0 1 0 0 0  80000000 80000000 ffffff00 00003010 09 0a  0 0 09 80000000 00000000 1 00002f10
1 0 0 0 0 1 0 0  00000000 00000001 00000100 00003014 0b 0c  0 0 0b 00000001 ffffffff 1 00003114
// Jumps load the PC whatever the zero flag
0 0 0 1 0 0 0 0  00000001 00000002 00000400 00004000 00 1f  0 0 00 00000002 00000003 1 00004400
0 0 0 1 0 0 0 0  00000000 00000000 fffff000 00004004 11 12  0 0 11 00000000 00000000 1 00003004
1 0 0 1 0 0 0 0  00000005 00000005 00000008 00004008 13 14  0 0 13 00000005 00000000 1 00004010
// Zero result without a branch
0 1 0 0 0 0 1 0  ffffffff 00000000 00000001 00005000 1f 00  1 0 1f 00000000 00000000 0 00005001

/* test/exe_tb.sv */
`timescale 1ns/1ps

module exe_tb;

    // Vector file layout, stimulus in columns 0 to 13 and expected values in 14 to 20
    localparam int    num_cols     = 21;
    localparam int    max_vectors  = 64;
    localparam int    mem_words    = num_cols * max_vectors;
    localparam int    reset_cycles = 16;
    localparam string input_file   = "test/exe_input.txt";
    // Pipeline register contents besides a vector index
    localparam int    item_none    = -1;
    localparam int    item_nop     = -2;

    logic                  clock;
    logic                  reset;
    exe_pkg::exe_operand_t operand;
    exe_pkg::exe_control_t control;
    exe_pkg::mem_bundle_t  mem_out;
    logic                  pc_load;
    logic [31:0]           pc_target;

    logic [31:0] vec_mem [0:mem_words-1];
    int          vec_count;
    // NOP fields that come back through the register
    logic [4:0]  nop_rt;
    logic [31:0] nop_data_b;

    exe_top u_exe_top (
        .clock       (clock),
        .reset       (reset),
        .operand_i   (operand),
        .control_i   (control),
        .mem_o       (mem_out),
        .pc_load_o   (pc_load),
        .pc_target_o (pc_target)
    );

    // 20 ns clock
    initial
    begin
        clock = 1'b0;
        forever
        begin
            #10 clock = ~clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Marks words that the file never wrote
    function automatic logic [31:0] fill_word(input int addr);
        fill_word = 32'hf00d_0000 ^ addr;
    endfunction

    task automatic compare_field(input string item, input string field,
                                 input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERR at %0t ns: %s field %s is %h, expected %h",
                     $time, item, field, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what, input int limit);
        $display("Timeout while waiting for %s, limit of %0d cycles exceeded", what, limit);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    endtask

    // Idle instruction, data fields are don't care
    task automatic drive_nop();
        logic [31:0] rnd;
        rnd                = $urandom();
        control            = '0;
        control.oper       = exe_pkg::oper_add;
        operand.data_a     = $urandom();
        operand.data_b     = $urandom();
        operand.data_imm   = $urandom();
        operand.npc        = $urandom();
        operand.regaddr_rt = rnd[4:0];
        operand.regaddr_rd = rnd[12:8];
        nop_rt             = rnd[4:0];
        nop_data_b         = operand.data_b;
    endtask

    task automatic drive_vector(input int vec);
        int base;
        base               = vec * num_cols;
        control.oper       = exe_pkg::oper_e'(vec_mem[base][3:0]);
        control.use_imm    = vec_mem[base + 1][0];
        control.reg_dst    = vec_mem[base + 2][0];
        control.is_jump    = vec_mem[base + 3][0];
        control.branch_eq  = vec_mem[base + 4][0];
        control.branch_ne  = vec_mem[base + 5][0];
        control.wb         = vec_mem[base + 6][1:0];
        control.mem        = vec_mem[base + 7][0];
        operand.data_a     = vec_mem[base + 8];
        operand.data_b     = vec_mem[base + 9];
        operand.data_imm   = vec_mem[base + 10];
        operand.npc        = vec_mem[base + 11];
        operand.regaddr_rt = vec_mem[base + 12][4:0];
        operand.regaddr_rd = vec_mem[base + 13][4:0];
    endtask

    task automatic check_vector(input int vec);
        int    base;
        string item;
        base = vec * num_cols;
        item = $sformatf("vector %0d", vec);
        compare_field(item, "wb", {30'd0, mem_out.wb}, vec_mem[base + 14]);
        compare_field(item, "mem", {31'd0, mem_out.mem}, vec_mem[base + 15]);
        compare_field(item, "regaddr", {27'd0, mem_out.regaddr}, vec_mem[base + 16]);
        compare_field(item, "store_data", mem_out.store_data, vec_mem[base + 17]);
        compare_field(item, "result", mem_out.result, vec_mem[base + 18]);
        compare_field(item, "pc_load", {31'd0, pc_load}, vec_mem[base + 19]);
        compare_field(item, "pc_target", pc_target, vec_mem[base + 20]);
    endtask

    // NOP writes nothing and never loads the PC
    task automatic check_nop();
        compare_field("nop", "wb", {30'd0, mem_out.wb}, 32'd0);
        compare_field("nop", "mem", {31'd0, mem_out.mem}, 32'd0);
        compare_field("nop", "regaddr", {27'd0, mem_out.regaddr}, {27'd0, nop_rt});
        compare_field("nop", "store_data", mem_out.store_data, nop_data_b);
        compare_field("nop", "pc_load", {31'd0, pc_load}, 32'd0);
    endtask

    task automatic load_vectors();
        int fd;
        int i;
        fd = $fopen(input_file, "r");
        if (fd == 0)
        begin
            $display("Vector file %s could not be opened", input_file);
            $display("CHECKS FAILED");
            $fatal(1, "missing vector file");
        end
        else
        begin
            $fclose(fd);
            for (i = 0; i < mem_words; i++)
            begin
                vec_mem[i] = fill_word(i);
            end
            $readmemh(input_file, vec_mem);
            vec_count = 0;
            // A vector is present when its oper word was written
            while (vec_count < max_vectors &&
                   vec_mem[vec_count * num_cols] !== fill_word(vec_count * num_cols))
            begin
                vec_count++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int wait_cycles;
        int run_cycles;
        int run_limit;
        int next_vec;
        int prev_item;

        void'($urandom(32'h2a00));
        reset = 1'b1;
        drive_nop();
        load_vectors();
        if (vec_count == 0)
        begin
            $display("Vector file %s holds no vectors", input_file);
            $display("CHECKS FAILED");
            $fatal(1, "empty vector file");
        end

        // Reset held for 16 rising edges
        wait_cycles = 0;
        while (wait_cycles < reset_cycles)
        begin
            @(posedge clock);
            wait_cycles++;
        end
        @(negedge clock);

        // Cleared register before the first vector
        compare_field("reset", "mem_o", mem_out[71:40], 32'd0);
        compare_field("reset", "mem_o", mem_out[39:8], 32'd0);
        compare_field("reset", "mem_o", {24'd0, mem_out[7:0]}, 32'd0);
        compare_field("reset", "pc_load", {31'd0, pc_load}, 32'd0);
        reset = 1'b0;

        // Back to back, a random NOP after every eighth vector
        run_limit  = 2 * vec_count + 8;
        run_cycles = 0;
        next_vec   = 0;
        prev_item  = item_none;
        while (next_vec < vec_count || prev_item != item_none)
        begin
            if (run_cycles >= run_limit)
                stop_on_timeout("vector results", run_limit);
            if (prev_item >= 0)
                check_vector(prev_item);
            else if (prev_item == item_nop)
                check_nop();
            if (next_vec < vec_count && next_vec % 8 == 0 && prev_item >= 0)
            begin
                drive_nop();
                prev_item = item_nop;
            end
            else if (next_vec < vec_count)
            begin
                drive_vector(next_vec);
                prev_item = next_vec;
                next_vec++;
            end
            else
            begin
                drive_nop();
                prev_item = item_none;
            end
            @(negedge clock);
            run_cycles++;
        end

        $display("Checked %0d vectors", vec_count);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
